//--- rtl/ctrl_pkg.sv
// shared sizes, encodings and control-word types for the RV32I control path
// the bit layout of ctrl_word_t is also the packed format of the test vectors
package ctrl_pkg;

    // stages after decode: execute, memory, writeback
    localparam int NUM_STAGES = 3;
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ORDER_W    = 64;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_e;

    // values follow branch funct3
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } cmp_op_e;

    typedef enum logic {
        alumux1_rs1 = 1'b0,
        alumux1_pc  = 1'b1
    } alumux1_e;

    typedef enum logic [2:0] {
        alumux2_i_imm = 3'd0,
        alumux2_u_imm = 3'd1,
        alumux2_b_imm = 3'd2,
        alumux2_s_imm = 3'd3,
        alumux2_j_imm = 3'd4,
        alumux2_rs2   = 3'd5
    } alumux2_e;

    typedef enum logic {
        cmpmux_rs2   = 1'b0,
        cmpmux_i_imm = 1'b1
    } cmpmux_e;

    typedef enum logic {
        marmux_pc  = 1'b0,
        marmux_alu = 1'b1
    } marmux_e;

    typedef enum logic [3:0] {
        rfmux_alu      = 4'd0,
        rfmux_br_en    = 4'd1,
        rfmux_u_imm    = 4'd2,
        rfmux_lw       = 4'd3,
        rfmux_pc_plus4 = 4'd4,
        rfmux_lb       = 4'd5,
        rfmux_lbu      = 4'd6,
        rfmux_lh       = 4'd7,
        rfmux_lhu      = 4'd8
    } regfilemux_e;

    // 11 bits
    typedef struct packed {
        alu_op_e  aluop;
        alumux1_e alumux1_sel;
        alumux2_e alumux2_sel;
        cmp_op_e  cmpop;
        cmpmux_e  cmp_sel;
    } exe_ctrl_t;

    // 3 bits
    typedef struct packed {
        logic    mem_read;
        logic    mem_write;
        marmux_e mar_sel;
    } mem_ctrl_t;

    // 10 bits
    typedef struct packed {
        logic                  ld_reg;
        regfilemux_e           regfilemux_sel;
        logic [REG_ADDR_W-1:0] rd_sel;
    } wb_ctrl_t;

    // 56 bits, exe in the top bits and the raw instruction at the bottom
    typedef struct packed {
        exe_ctrl_t       exe;
        mem_ctrl_t       mem;
        wb_ctrl_t        wb;
        logic [XLEN-1:0] instr;
    } ctrl_word_t;

    // 109 bits
    typedef struct packed {
        logic [ORDER_W-1:0] order;
        logic [XLEN-1:0]    instr;
        mem_ctrl_t          mem;
        wb_ctrl_t           wb;
    } commit_t;

endpackage

//--- rtl/instr_decoder.sv
`timescale 1ns/1ps
// RV32I control decoder and decode register
// builds the execute, memory and writeback controls from a fetched instruction
// the word and valid bit load on an edge where i_ld is high
module instr_decoder (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic [ctrl_pkg::XLEN-1:0] i_instr,
    input  logic                      i_instr_valid,
    input  logic                      i_ld,
    output ctrl_pkg::ctrl_word_t      o_word,
    output logic                      o_valid
);
    import ctrl_pkg::*;

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic                  funct7_b5;
    logic [REG_ADDR_W-1:0] rd;
    logic                  is_reg;
    exe_ctrl_t             exe;
    mem_ctrl_t             mem;
    wb_ctrl_t              wb;
    ctrl_word_t            word_q;
    logic                  valid_q;

    assign opcode    = opcode_e'(i_instr[6:0]);
    assign funct3    = i_instr[14:12];
    assign funct7_b5 = i_instr[30];
    assign rd        = i_instr[11:7];
    assign is_reg    = (opcode == op_reg);

    always_comb begin
        // inactive word, ALU add
        exe.aluop          = alu_add;
        exe.alumux1_sel    = alumux1_rs1;
        exe.alumux2_sel    = alumux2_i_imm;
        exe.cmpop          = beq;
        exe.cmp_sel        = cmpmux_rs2;
        mem.mem_read       = 1'b0;
        mem.mem_write      = 1'b0;
        mem.mar_sel        = marmux_pc;
        wb.ld_reg          = 1'b0;
        wb.regfilemux_sel  = rfmux_alu;
        wb.rd_sel          = '0;

        case (opcode)
            op_lui: begin
                wb.ld_reg         = 1'b1;
                wb.regfilemux_sel = rfmux_u_imm;
                wb.rd_sel         = rd;
            end
            op_auipc: begin
                exe.alumux1_sel = alumux1_pc;
                exe.alumux2_sel = alumux2_u_imm;
                wb.ld_reg       = 1'b1;
                wb.rd_sel       = rd;
            end
            op_jal, op_jalr: begin
                // target is pc + j imm or rs1 + i imm, rd gets the link
                if (opcode == op_jal) begin
                    exe.alumux1_sel = alumux1_pc;
                    exe.alumux2_sel = alumux2_j_imm;
                end
                wb.ld_reg         = 1'b1;
                wb.regfilemux_sel = rfmux_pc_plus4;
                wb.rd_sel         = rd;
            end
            op_br: begin
                exe.alumux1_sel = alumux1_pc;
                exe.alumux2_sel = alumux2_b_imm;
                exe.cmpop       = cmp_op_e'(funct3);
            end
            op_load: begin
                mem.mem_read = 1'b1;
                mem.mar_sel  = marmux_alu;
                wb.ld_reg    = 1'b1;
                wb.rd_sel    = rd;
                case (funct3)
                    3'b000:  wb.regfilemux_sel = rfmux_lb;
                    3'b001:  wb.regfilemux_sel = rfmux_lh;
                    3'b010:  wb.regfilemux_sel = rfmux_lw;
                    3'b100:  wb.regfilemux_sel = rfmux_lbu;
                    3'b101:  wb.regfilemux_sel = rfmux_lhu;
                    default: ;
                endcase
            end
            op_store: begin
                exe.alumux2_sel = alumux2_s_imm;
                mem.mem_write   = 1'b1;
                mem.mar_sel     = marmux_alu;
            end
            op_imm, op_reg: begin
                wb.ld_reg = 1'b1;
                wb.rd_sel = rd;
                if (is_reg) begin
                    exe.alumux2_sel = alumux2_rs2;
                end
                case (funct3)
                    3'b000:  exe.aluop = (is_reg && funct7_b5) ? alu_sub : alu_add;
                    3'b001:  exe.aluop = alu_sll;
                    3'b010, 3'b011: begin
                        // slt and sltu go through the comparator
                        exe.cmpop         = (funct3[0]) ? bltu : blt;
                        exe.cmp_sel       = is_reg ? cmpmux_rs2 : cmpmux_i_imm;
                        wb.regfilemux_sel = rfmux_br_en;
                    end
                    3'b100:  exe.aluop = alu_xor;
                    3'b101:  exe.aluop = funct7_b5 ? alu_sra : alu_srl;
                    3'b110:  exe.aluop = alu_or;
                    default: exe.aluop = alu_and;
                endcase
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_q <= 1'b0;
        end else if (i_ld) begin
            valid_q <= i_instr_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_ld) begin
            word_q <= '{exe: exe, mem: mem, wb: wb, instr: i_instr};
        end
    end

    assign o_word  = word_q;
    assign o_valid = valid_q;

    // no decoded word may read and write memory in the same stage
    a_no_rw: assert property (@(posedge i_clk) disable iff (i_rst)
        o_valid |-> !(word_q.mem.mem_read && word_q.mem.mem_write));

endmodule

//--- rtl/pipe_ctrl_stage.sv
`timescale 1ns/1ps
// one pipeline register for a control word and its valid bit
// holds while stalled or while a later stage holds, and sends a bubble
// forward while its own ready is low
module pipe_ctrl_stage (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  ctrl_pkg::ctrl_word_t i_word,
    input  logic                 i_valid,
    input  logic                 i_rdy,
    input  logic                 i_hold_next,
    output ctrl_pkg::ctrl_word_t o_word,
    output logic                 o_valid,
    output logic                 o_hold
);
    import ctrl_pkg::*;

    ctrl_word_t word_q;
    logic       valid_q;
    logic       stall;

    // valid item still being worked on
    assign stall  = valid_q && !i_rdy;
    assign o_hold = stall || i_hold_next;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_q <= 1'b0;
        end else if (!o_hold) begin
            valid_q <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!o_hold) begin
            word_q <= i_word;
        end
    end

    assign o_word = word_q;
    // masked while stalled so the next stage takes a bubble
    assign o_valid = valid_q && !stall;

    // a hold from here or downstream freezes the stored word
    a_hold_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        o_hold |=> $stable(word_q) && $stable(valid_q));

endmodule

//--- rtl/commit_unit.sv
`timescale 1ns/1ps
// retires control words leaving the last stage
// every valid word becomes a commit record with the running order number
module commit_unit (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  ctrl_pkg::ctrl_word_t i_word,
    input  logic                 i_valid,
    output logic                 o_commit_valid,
    output ctrl_pkg::commit_t    o_commit
);
    import ctrl_pkg::*;

    logic [ORDER_W-1:0] order_q;
    logic [ORDER_W-1:0] last_order_q;
    logic               seen_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            order_q <= '0;
        end else if (i_valid) begin
            order_q <= order_q + 1'b1;
        end
    end

    assign o_commit_valid = i_valid;

    always_comb begin
        o_commit.order = order_q;
        o_commit.instr = i_word.instr;
        o_commit.mem   = i_word.mem;
        o_commit.wb    = i_word.wb;
    end

    // order of the previous commit
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            seen_q <= 1'b0;
        end else if (o_commit_valid) begin
            seen_q       <= 1'b1;
            last_order_q <= o_commit.order;
        end
    end

    a_order_step: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_commit_valid && seen_q) |-> (o_commit.order == last_order_q + 1'b1));

endmodule

//--- rtl/pipeline_control.sv
`timescale 1ns/1ps
// control path of the five-stage RV32I pipeline
// decode register, execute/memory/writeback stage registers and the commit unit
// i_stage_rdy[0] is execute; a new instruction is taken on edges with o_fetch_ld high
module pipeline_control (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [ctrl_pkg::XLEN-1:0]       i_instr,
    input  logic                            i_instr_valid,
    input  logic [ctrl_pkg::NUM_STAGES-1:0] i_stage_rdy,
    output logic                            o_fetch_ld,
    output logic                            o_commit_valid,
    output ctrl_pkg::commit_t               o_commit
);
    import ctrl_pkg::*;

    // index 0 is the decode register, index i+1 is the output of stage i
    ctrl_word_t          stage_word [0:NUM_STAGES];
    logic [NUM_STAGES:0] stage_valid;
    // hold of stage i, the top bit is beyond the last stage
    logic [NUM_STAGES:0] stage_hold;

    assign stage_hold[NUM_STAGES] = 1'b0;
    assign o_fetch_ld             = !stage_hold[0];

    instr_decoder u_decoder (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_instr       (i_instr),
        .i_instr_valid (i_instr_valid),
        .i_ld          (!stage_hold[0]),
        .o_word        (stage_word[0]),
        .o_valid       (stage_valid[0])
    );

    for (genvar i = 0; i < NUM_STAGES; i++) begin : g_stage
        pipe_ctrl_stage u_stage (
            .i_clk       (clk),
            .i_rst       (rst),
            .i_word      (stage_word[i]),
            .i_valid     (stage_valid[i]),
            .i_rdy       (i_stage_rdy[i]),
            .i_hold_next (stage_hold[i+1]),
            .o_word      (stage_word[i+1]),
            .o_valid     (stage_valid[i+1]),
            .o_hold      (stage_hold[i])
        );
    end

    commit_unit u_commit (
        .i_clk          (clk),
        .i_rst          (rst),
        .i_word         (stage_word[NUM_STAGES]),
        .i_valid        (stage_valid[NUM_STAGES]),
        .o_commit_valid (o_commit_valid),
        .o_commit       (o_commit)
    );

endmodule

//--- bench/tb_pipeline_control.sv
`timescale 1ns/1ps
// testbench for pipeline_control
// vectors from bench/control_tests.txt are issued under several ready patterns
// and every commit is checked against a scoreboard of accepted instructions
module tb_pipeline_control;
    import ctrl_pkg::*;

    localparam int                    MAX_TESTS  = 64;
    localparam int                    WAIT_LIMIT = 200;
    localparam logic [NUM_STAGES-1:0] ALL_RDY    = '1;

    logic                  clk;
    logic                  rst;
    logic [XLEN-1:0]       i_instr;
    logic                  i_instr_valid;
    logic [NUM_STAGES-1:0] i_stage_rdy;
    logic                  o_fetch_ld;
    logic                  o_commit_valid;
    commit_t               o_commit;

    logic [XLEN-1:0]    test_instr [MAX_TESTS];
    ctrl_word_t         test_word  [MAX_TESTS];
    int                 n_tests;
    // accepted instructions and the edge at which each was taken
    ctrl_word_t         exp_q [$];
    int                 acc_q [$];
    logic [ORDER_W-1:0] exp_order;
    int                 cycle_cnt;
    int                 commit_cnt;
    bit                 check_latency;
    int                 value_errs;
    int                 seq_errs;
    int                 timeout_errs;
    integer             seed = 32'h4ae9_579d;

    pipeline_control UUT (
        .clk            (clk),
        .rst            (rst),
        .i_instr        (i_instr),
        .i_instr_valid  (i_instr_valid),
        .i_stage_rdy    (i_stage_rdy),
        .o_fetch_ld     (o_fetch_ld),
        .o_commit_valid (o_commit_valid),
        .o_commit       (o_commit)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    function automatic int pick_test();
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n_tests);
    endfunction

    // each stage ready about three cycles in four
    function automatic logic [NUM_STAGES-1:0] rand_ready();
        logic [31:0] r;
        r = $random(seed);
        return r[NUM_STAGES-1:0] | r[2*NUM_STAGES-1:NUM_STAGES];
    endfunction

    function automatic logic rand_valid();
        logic [31:0] r;
        r = $random(seed);
        return r[0] | r[1];
    endfunction

    // compare one commit with the oldest accepted instruction
    task automatic check_commit();
        ctrl_word_t exp_word;
        int         acc_cycle;
        commit_cnt++;
        assert (exp_q.size() > 0) else begin
            $display("unexpected commit of %h with nothing in flight", o_commit.instr);
            seq_errs++;
        end
        if (exp_q.size() > 0) begin
            exp_word  = exp_q.pop_front();
            acc_cycle = acc_q.pop_front();
            assert (o_commit.instr == exp_word.instr) else begin
                $display("[FAIL] o_commit.instr: got %h, expected %h",
                         o_commit.instr, exp_word.instr);
                value_errs++;
            end
            assert (o_commit.mem == exp_word.mem) else begin
                $display("[FAIL] o_commit.mem: got %h, expected %h (instr %h)",
                         o_commit.mem, exp_word.mem, exp_word.instr);
                value_errs++;
            end
            assert (o_commit.wb == exp_word.wb) else begin
                $display("[FAIL] o_commit.wb: got %h, expected %h (instr %h)",
                         o_commit.wb, exp_word.wb, exp_word.instr);
                value_errs++;
            end
            if (check_latency) begin
                assert (cycle_cnt == acc_cycle + 3) else begin
                    $display("instruction %h committed %0d edges after acceptance, not 3",
                             exp_word.instr, cycle_cnt - acc_cycle);
                    seq_errs++;
                end
            end
        end
        assert (o_commit.order == exp_order) else begin
            $display("[FAIL] o_commit.order: got %h, expected %h", o_commit.order, exp_order);
            value_errs++;
        end
        exp_order++;
    endtask

    // one clock: drive after the edge, sample shortly before the next one
    task automatic run_cycle(input logic [XLEN-1:0] instr, input logic vld,
                             input ctrl_word_t exp_word, input logic [NUM_STAGES-1:0] rdy);
        @(posedge clk);
        cycle_cnt++;
        #10;
        rst           = 1'b0;
        i_instr       = instr;
        i_instr_valid = vld;
        i_stage_rdy   = rdy;
        #70;
        if (o_commit_valid) begin
            check_commit();
        end
        if (o_fetch_ld && i_instr_valid) begin
            exp_q.push_back(exp_word);
            acc_q.push_back(cycle_cnt + 1);
        end
    endtask

    task automatic apply_reset();
        int n;
        for (n = 0; n < 10; n++) begin
            @(posedge clk);
            cycle_cnt++;
            #10;
            rst           = 1'b1;
            i_instr_valid = 1'b0;
            i_stage_rdy   = ALL_RDY;
        end
        exp_q.delete();
        acc_q.delete();
        exp_order = '0;
        #60;
        assert (o_fetch_ld) else begin
            $display("[FAIL] o_fetch_ld after reset: got %h, expected 1", o_fetch_ld);
            value_errs++;
        end
        assert (!o_commit_valid) else begin
            $display("[FAIL] o_commit_valid after reset: got %h, expected 0", o_commit_valid);
            value_errs++;
        end
    endtask

    // idle input until everything accepted has committed
    task automatic drain(input bit rand_rdy);
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < WAIT_LIMIT) begin
            run_cycle('0, 1'b0, '0, rand_rdy ? rand_ready() : ALL_RDY);
            n++;
        end
        assert (exp_q.size() == 0) else begin
            $display("timeout: %0d accepted instructions never committed", exp_q.size());
            timeout_errs++;
        end
    endtask

    initial begin
        int                            i;
        int                            k;
        int                            n;
        int                            fd;
        int                            r;
        int                            base;
        logic [XLEN-1:0]               ins;
        logic [$bits(ctrl_word_t)-1:0] raw;
        logic [8*256-1:0]              text_line;
        rst           = 1'b1;
        i_instr       = '0;
        i_instr_valid = 1'b0;
        i_stage_rdy   = ALL_RDY;
        n_tests       = 0;
        cycle_cnt     = 0;
        commit_cnt    = 0;
        exp_order     = '0;
        check_latency = 1'b0;
        value_errs    = 0;
        seq_errs      = 0;
        timeout_errs  = 0;

        fd = $fopen("bench/control_tests.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                r = $fscanf(fd, "%h %h\n", ins, raw);
                if (r == 2) begin
                    test_instr[n_tests] = ins;
                    test_word[n_tests]  = raw;
                    n_tests++;
                end else begin
                    // comment line
                    r = $fgets(text_line, fd);
                end
            end
            $fclose(fd);
        end
        assert (n_tests > 0) else begin
            $display("no test vectors could be read from bench/control_tests.txt");
            seq_errs++;
        end

        apply_reset();
        if (n_tests > 0) begin
            // every vector in file order, then a back-to-back stream
            check_latency = 1'b1;
            base = commit_cnt;
            for (i = 0; i < n_tests; i++) begin
                run_cycle(test_instr[i], 1'b1, test_word[i], ALL_RDY);
            end
            drain(1'b0);
            for (i = 0; i < 24; i++) begin
                k = pick_test();
                run_cycle(test_instr[k], 1'b1, test_word[k], ALL_RDY);
            end
            drain(1'b0);
            check_latency = 1'b0;
            // with every stage ready each offered instruction is taken
            assert (commit_cnt == base + n_tests + 24) else begin
                $display("%0d of %0d instructions committed with every stage ready",
                         commit_cnt - base, n_tests + 24);
                seq_errs++;
            end

            // random ready levels with gaps in the input
            for (i = 0; i < 120; i++) begin
                k = pick_test();
                run_cycle(test_instr[k], rand_valid(), test_word[k], rand_ready());
            end
            drain(1'b1);

            // writeback held off
            base = commit_cnt;
            n = 0;
            while (o_fetch_ld && n < WAIT_LIMIT) begin
                k = pick_test();
                run_cycle(test_instr[k], 1'b1, test_word[k], ALL_RDY >> 1);
                n++;
            end
            assert (!o_fetch_ld) else begin
                $display("timeout waiting for o_fetch_ld to fall under a writeback stall");
                timeout_errs++;
            end
            for (i = 0; i < 5; i++) begin
                k = pick_test();
                run_cycle(test_instr[k], 1'b1, test_word[k], ALL_RDY >> 1);
            end
            assert (commit_cnt == base) else begin
                $display("a commit appeared while writeback was not ready");
                seq_errs++;
            end
            drain(1'b0);
            assert (o_fetch_ld) else begin
                $display("[FAIL] o_fetch_ld after the stall: got %h, expected 1", o_fetch_ld);
                value_errs++;
            end

            // reset with instructions in flight, order restarts at 0
            for (i = 0; i < 6; i++) begin
                k = pick_test();
                run_cycle(test_instr[k], 1'b1, test_word[k], ALL_RDY);
            end
            apply_reset();
            for (i = 0; i < 6; i++) begin
                run_cycle('0, 1'b0, '0, ALL_RDY);
            end
            for (i = 0; i < 4; i++) begin
                k = pick_test();
                run_cycle(test_instr[k], 1'b1, test_word[k], ALL_RDY);
            end
            drain(1'b0);
        end

        $display("errors: %0d value, %0d sequence, %0d timeout",
                 value_errs, seq_errs, timeout_errs);
        if (value_errs + seq_errs + timeout_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- bench/control_tests.txt
// instr    ctrl_word_t {exe[55:45] mem[44:42] wb[41:32] instr[31:0]}
123450B7 000241123450B7
00001117 12020200001117
010001EF 180283010001EF
00028267 00028400028267
00208063 14000000208063
00209063 14400000209063
0020C063 1500000020C063
0020D063 1540000020D063
0020E063 1580000020E063
0020F063 15C0000020F063
00408303 0016A600408303
00409303 0016E600409303
0040A303 0016660040A303
0040C303 0016C60040C303
0040D303 0017060040D303
00208423 060C0000208423
00209423 060C0000209423
0020A423 060C000020A423
00508393 00020700508393
00509393 20020700509393
0050A393 0122270050A393
0050B393 01A2270050B393
0050C393 8002070050C393
0050D393 A002070050D393
4050D393 4002074050D393
0050E393 C002070050E393
0050F393 E002070050F393
00208433 0A020800208433
40208433 6A020840208433
00209433 2A020800209433
0020A433 0B02280020A433
0020B433 0B82280020B433
0020C433 8A02080020C433
0020D433 AA02080020D433
4020D433 4A02084020D433
0020E433 CA02080020E433
0020F433 EA02080020F433
0000008B 0000000000008B

//--- tb.f
rtl/ctrl_pkg.sv
rtl/instr_decoder.sv
rtl/pipe_ctrl_stage.sv
rtl/commit_unit.sv
rtl/pipeline_control.sv
bench/tb_pipeline_control.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_pipeline_control
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Done: errors found
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAILED: run ended early"; exit 1; fi
	@echo "PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
